// File: hw/cnn_pkg.sv
`default_nettype none

package cnn_pkg;

	// data widths
	localparam int PIX_BITS  = 8;
	localparam int W_BITS    = 8;
	localparam int ACC_BITS  = 20;
	localparam int BIAS_BITS = 16;

	// frame limits, row and column need 5 bits to hold 16
	localparam int MAX_W     = 16;
	localparam int MAX_H     = 16;
	localparam int DIM_BITS  = 5;
	localparam int FRAME_MAX = MAX_W * MAX_H;
	localparam int IDX_BITS  = 8;
	localparam int DEF_DIM   = 8;

	// 3x3 kernel
	localparam int N_TAPS = 9;

	// register index sits in haddr[5:2]
	localparam int REG_IDX_BITS = 4;

	// ahb transfer types that carry data
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
	localparam logic [1:0] HTRANS_SEQ    = 2'b11;

	typedef logic        [PIX_BITS-1:0] pix_t;
	typedef logic signed [W_BITS-1:0]   weight_t;
	typedef logic signed [ACC_BITS-1:0] acc_t;
	typedef logic        [DIM_BITS-1:0] dim_t;
	typedef logic        [IDX_BITS-1:0] idx_t;

	// control register map
	typedef enum logic [REG_IDX_BITS-1:0] {
		REG_WIDTH_HEIGHT = 4'd1,
		REG_LAYER_CONFIG = 4'd4,
		REG_INPUT_IMAGE  = 4'd5,
		REG_LAYER_START  = 4'd8,
		REG_LAYER_DONE   = 4'd9,
		REG_BIAS         = 4'd10,
		REG_WEIGHTS0     = 4'd11,
		REG_WEIGHTS1     = 4'd12,
		REG_WEIGHTS2     = 4'd13
	} reg_addr_e;

	typedef enum logic {ACT_RELU = 1'b0, ACT_LINEAR = 1'b1} act_e;

	typedef enum logic {SEQ_IDLE = 1'b0, SEQ_RUN = 1'b1} seq_state_e;

endpackage

`default_nettype wire

// File: hw/cnn_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module cnn_reg_bank (
	input  wire                                   clk,
	input  wire                                   rstn,
	input  wire                                   sl_hsel_i,
	input  wire                                   sl_hready_i,
	input  wire         [1:0]                     sl_htrans_i,
	input  wire                                   sl_hwrite_i,
	input  wire         [31:0]                    sl_haddr_i,
	input  wire         [31:0]                    sl_hwdata_i,
	input  wire                                   done_i,
	output logic        [31:0]                    sl_hrdata_o,
	output logic                                  img_we_o,
	output cnn_pkg::idx_t                         img_addr_o,
	output cnn_pkg::pix_t                         img_data_o,
	output logic                                  start_o,
	output cnn_pkg::dim_t                         width_o,
	output cnn_pkg::dim_t                         height_o,
	output cnn_pkg::act_e                         act_o,
	output logic        [2:0]                     act_shift_o,
	output logic signed [cnn_pkg::BIAS_BITS-1:0]  bias_o,
	output cnn_pkg::weight_t                      weights_o [cnn_pkg::N_TAPS]
);
	import cnn_pkg::*;

	reg_addr_e reg_sel_q;
	idx_t      pix_idx_q;
	logic      wr_q;
	logic      xfer;
	logic      done_q;

	// ----------------------------------------
	// address phase
	// ----------------------------------------
	// only nonseq and seq carry a transfer
	assign xfer = sl_hsel_i && sl_hready_i &&
		(sl_htrans_i == HTRANS_NONSEQ || sl_htrans_i == HTRANS_SEQ);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			reg_sel_q <= REG_WIDTH_HEIGHT;
			pix_idx_q <= '0;
			wr_q      <= 1'b0;
		end else if (xfer) begin
			reg_sel_q <= reg_addr_e'(sl_haddr_i[2 +: REG_IDX_BITS]);
			// pixel index above the register index bits
			pix_idx_q <= sl_haddr_i[6 +: IDX_BITS];
			wr_q      <= sl_hwrite_i;
		end else begin
			wr_q <= 1'b0;
		end
	end

	// ----------------------------------------
	// data phase
	// ----------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			width_o     <= dim_t'(DEF_DIM);
			height_o    <= dim_t'(DEF_DIM);
			act_o       <= ACT_RELU;
			act_shift_o <= '0;
			bias_o      <= '0;
			for (int k = 0; k < N_TAPS; k++) begin
				weights_o[k] <= '0;
			end
		end else if (wr_q) begin
			case (reg_sel_q)
				REG_WIDTH_HEIGHT: begin
					width_o  <= sl_hwdata_i[0 +: DIM_BITS];
					height_o <= sl_hwdata_i[16 +: DIM_BITS];
				end
				REG_LAYER_CONFIG: begin
					act_o       <= act_e'(sl_hwdata_i[3]);
					act_shift_o <= sl_hwdata_i[15:13];
				end
				REG_BIAS: bias_o <= sl_hwdata_i[BIAS_BITS-1:0];
				// four taps per word with the lowest byte first
				REG_WEIGHTS0: begin
					for (int k = 0; k < 4; k++) begin
						weights_o[k] <= sl_hwdata_i[8*k +: W_BITS];
					end
				end
				REG_WEIGHTS1: begin
					for (int k = 0; k < 4; k++) begin
						weights_o[4+k] <= sl_hwdata_i[8*k +: W_BITS];
					end
				end
				REG_WEIGHTS2: weights_o[8] <= sl_hwdata_i[W_BITS-1:0];
				default: ;
			endcase
		end
	end

	// strobes toward the datapath
	assign start_o    = wr_q && (reg_sel_q == REG_LAYER_START) && sl_hwdata_i[0];
	assign img_we_o   = wr_q && (reg_sel_q == REG_INPUT_IMAGE);
	assign img_addr_o = pix_idx_q;
	assign img_data_o = sl_hwdata_i[PIX_BITS-1:0];

	// start wins over a late done
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			done_q <= 1'b0;
		end else if (start_o) begin
			done_q <= 1'b0;
		end else if (done_i) begin
			done_q <= 1'b1;
		end
	end

	// readback in data phase
	always_comb begin
		case (reg_sel_q)
			REG_WIDTH_HEIGHT: sl_hrdata_o = {11'd0, height_o, 11'd0, width_o};
			REG_LAYER_CONFIG: sl_hrdata_o = {16'd0, act_shift_o, 9'd0, act_o, 3'd0};
			REG_LAYER_DONE:   sl_hrdata_o = {31'd0, done_q};
			REG_BIAS:         sl_hrdata_o = {16'd0, bias_o};
			REG_WEIGHTS0:     sl_hrdata_o = {weights_o[3], weights_o[2], weights_o[1], weights_o[0]};
			REG_WEIGHTS1:     sl_hrdata_o = {weights_o[7], weights_o[6], weights_o[5], weights_o[4]};
			REG_WEIGHTS2:     sl_hrdata_o = {24'd0, weights_o[8]};
			// start is a pulse and the image is write only
			default:          sl_hrdata_o = 32'd0;
		endcase
	end

	// each strobe comes from a write address phase to its own register
	a_start_src: assert property (@(posedge clk) disable iff (!rstn)
		start_o |-> $past(xfer && sl_hwrite_i &&
			(sl_haddr_i[2 +: REG_IDX_BITS] == REG_LAYER_START)));
	a_img_src: assert property (@(posedge clk) disable iff (!rstn)
		img_we_o |-> $past(xfer && sl_hwrite_i &&
			(sl_haddr_i[2 +: REG_IDX_BITS] == REG_INPUT_IMAGE)));

endmodule

`default_nettype wire

// File: hw/frame_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer (
	input  wire                clk,
	input  wire                rstn,
	input  wire                start_i,
	input  wire cnn_pkg::dim_t width_i,
	input  wire cnn_pkg::dim_t height_i,
	output logic               pos_vld_o,
	output cnn_pkg::dim_t      row_o,
	output cnn_pkg::dim_t      col_o,
	output logic               last_o
);
	import cnn_pkg::*;

	seq_state_e state_q;
	dim_t       w_q;
	dim_t       h_q;
	dim_t       row_cnt;
	dim_t       col_cnt;
	logic       at_eol;
	logic       at_eof;

	// end of line and end of frame
	assign at_eol = (col_cnt == w_q - dim_t'(1));
	assign at_eof = at_eol && (row_cnt == h_q - dim_t'(1));

	// ----------------------------------------
	// fsm and raster counters
	// ----------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state_q <= SEQ_IDLE;
			w_q     <= '0;
			h_q     <= '0;
			row_cnt <= '0;
			col_cnt <= '0;
		end else begin
			case (state_q)
				SEQ_IDLE: begin
					// frame size frozen for the whole run
					if (start_i) begin
						state_q <= SEQ_RUN;
						w_q     <= width_i;
						h_q     <= height_i;
						row_cnt <= '0;
						col_cnt <= '0;
					end
				end
				SEQ_RUN: begin
					// start ignored here
					if (at_eol) begin
						col_cnt <= '0;
						row_cnt <= row_cnt + dim_t'(1);
					end else begin
						col_cnt <= col_cnt + dim_t'(1);
					end
					if (at_eof) begin
						state_q <= SEQ_IDLE;
					end
				end
				default: state_q <= SEQ_IDLE;
			endcase
		end
	end

	// registered position outputs
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			pos_vld_o <= 1'b0;
			last_o    <= 1'b0;
		end else begin
			pos_vld_o <= (state_q == SEQ_RUN);
			last_o    <= (state_q == SEQ_RUN) && at_eof;
		end
	end

	always_ff @(posedge clk) begin
		row_o <= row_cnt;
		col_o <= col_cnt;
	end

	// positions stay inside the frame latched at start
	a_col_in_frame: assert property (@(posedge clk) disable iff (!rstn)
		pos_vld_o |-> (col_o < w_q));
	a_row_in_frame: assert property (@(posedge clk) disable iff (!rstn)
		pos_vld_o |-> (row_o < h_q));

endmodule

`default_nettype wire

// File: hw/window_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module window_fetch (
	input  wire                clk,
	input  wire                rstn,
	input  wire                img_we_i,
	input  wire cnn_pkg::idx_t img_addr_i,
	input  wire cnn_pkg::pix_t img_data_i,
	input  wire cnn_pkg::dim_t width_i,
	input  wire cnn_pkg::dim_t height_i,
	input  wire                pos_vld_i,
	input  wire cnn_pkg::dim_t row_i,
	input  wire cnn_pkg::dim_t col_i,
	input  wire                last_i,
	output logic               win_vld_o,
	output logic               win_last_o,
	output cnn_pkg::pix_t      taps_o [cnn_pkg::N_TAPS]
);
	import cnn_pkg::*;

	// image buffer, raster order, stride = width
	pix_t img_mem [FRAME_MAX];

	logic first_row;
	logic last_row;
	logic first_col;
	logic last_col;
	idx_t center;
	idx_t row_base [3];
	logic row_ok [3];
	logic col_ok [3];
	idx_t nbr_idx [N_TAPS];
	logic nbr_ok [N_TAPS];

	// cpu load port
	always_ff @(posedge clk) begin
		if (img_we_i) begin
			img_mem[img_addr_i] <= img_data_i;
		end
	end

	// ----------------------------------------
	// borders and neighbour indices
	// ----------------------------------------
	assign first_row = (row_i == '0);
	assign last_row  = (row_i == height_i - dim_t'(1));
	assign first_col = (col_i == '0);
	assign last_col  = (col_i == width_i - dim_t'(1));

	// 8-bit wrap is harmless, out of frame taps get masked
	assign center = idx_t'(row_i) * idx_t'(width_i) + idx_t'(col_i);

	always_comb begin
		// rows r-1, r, r+1
		row_base[0] = center - idx_t'(width_i);
		row_base[1] = center;
		row_base[2] = center + idx_t'(width_i);
		row_ok[0]   = !first_row;
		row_ok[1]   = 1'b1;
		row_ok[2]   = !last_row;
		// columns c-1, c, c+1
		col_ok[0]   = !first_col;
		col_ok[1]   = 1'b1;
		col_ok[2]   = !last_col;
		for (int k = 0; k < N_TAPS; k++) begin
			nbr_idx[k] = row_base[k / 3] + idx_t'(k % 3) - idx_t'(1);
			nbr_ok[k]  = row_ok[k / 3] && col_ok[k % 3];
		end
	end

	// ----------------------------------------
	// registered window
	// ----------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			win_vld_o  <= 1'b0;
			win_last_o <= 1'b0;
		end else begin
			win_vld_o  <= pos_vld_i;
			win_last_o <= pos_vld_i && last_i;
		end
	end

	// zero padding outside the frame
	always_ff @(posedge clk) begin
		for (int k = 0; k < N_TAPS; k++) begin
			taps_o[k] <= nbr_ok[k] ? img_mem[nbr_idx[k]] : '0;
		end
	end

endmodule

`default_nettype wire

// File: hw/mac_array.sv
`timescale 1ns/1ps
`default_nettype none

module mac_array (
	input  wire                   clk,
	input  wire                   rstn,
	input  wire                   win_vld_i,
	input  wire                   win_last_i,
	input  wire cnn_pkg::pix_t    taps_i [cnn_pkg::N_TAPS],
	input  wire cnn_pkg::weight_t weights_i [cnn_pkg::N_TAPS],
	output logic                  acc_vld_o,
	output logic                  acc_last_o,
	output cnn_pkg::acc_t         acc_o
);
	import cnn_pkg::*;

	// unsigned pixel times signed weight, 17 bits
	logic signed [PIX_BITS+W_BITS:0] prod_q [N_TAPS];
	logic                            prod_vld_q;
	logic                            prod_last_q;
	acc_t                            sum;

	// ----------------------------------------
	// stage 1, products
	// ----------------------------------------
	always_ff @(posedge clk) begin
		for (int k = 0; k < N_TAPS; k++) begin
			// zero msb keeps the pixel positive
			prod_q[k] <= $signed({1'b0, taps_i[k]}) * weights_i[k];
		end
	end

	// ----------------------------------------
	// stage 2, adder tree
	// ----------------------------------------
	// nine taps fit 20 bits with headroom
	always_comb begin
		sum = '0;
		for (int k = 0; k < N_TAPS; k++) begin
			sum = sum + acc_t'(prod_q[k]);
		end
	end

	always_ff @(posedge clk) begin
		acc_o <= sum;
	end

	// valid and last ride along
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			prod_vld_q  <= 1'b0;
			prod_last_q <= 1'b0;
			acc_vld_o   <= 1'b0;
			acc_last_o  <= 1'b0;
		end else begin
			prod_vld_q  <= win_vld_i;
			prod_last_q <= win_vld_i && win_last_i;
			acc_vld_o   <= prod_vld_q;
			acc_last_o  <= prod_last_q;
		end
	end

endmodule

`default_nettype wire

// File: hw/post_proc.sv
`timescale 1ns/1ps
`default_nettype none

module post_proc (
	input  wire                                  clk,
	input  wire                                  rstn,
	input  wire                                  acc_vld_i,
	input  wire                                  acc_last_i,
	input  wire cnn_pkg::acc_t                   acc_i,
	input  wire signed [cnn_pkg::BIAS_BITS-1:0]  bias_i,
	input  wire cnn_pkg::act_e                   act_i,
	input  wire        [2:0]                     act_shift_i,
	output logic                                 out_valid_o,
	output cnn_pkg::pix_t                        out_pixel_o,
	output logic                                 done_o
);
	import cnn_pkg::*;

	// one guard bit for the bias add
	logic signed [ACC_BITS:0] biased;
	logic signed [ACC_BITS:0] shifted;
	pix_t                     pix_next;

	// ----------------------------------------
	// bias, shift, activation
	// ----------------------------------------
	always_comb begin
		// both operands sign extended to 21 bits
		biased  = {acc_i[ACC_BITS-1], acc_i} +
			{{(ACC_BITS+1-BIAS_BITS){bias_i[BIAS_BITS-1]}}, bias_i};
		shifted = biased >>> act_shift_i;
		if (act_i == ACT_RELU) begin
			// relu gives an unsigned byte
			if (shifted < 0) begin
				pix_next = '0;
			end else if (shifted > 255) begin
				pix_next = 8'hff;
			end else begin
				pix_next = shifted[PIX_BITS-1:0];
			end
		end else begin
			// linear gives a signed byte
			if (shifted < -128) begin
				pix_next = 8'h80;
			end else if (shifted > 127) begin
				pix_next = 8'h7f;
			end else begin
				pix_next = shifted[PIX_BITS-1:0];
			end
		end
	end

	always_ff @(posedge clk) begin
		out_pixel_o <= pix_next;
	end

	// output strobes
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			out_valid_o <= 1'b0;
			done_o      <= 1'b0;
		end else begin
			out_valid_o <= acc_vld_i;
			done_o      <= acc_vld_i && acc_last_i;
		end
	end

	// a frame always ends in a bubble before the next one
	a_done_gap: assert property (@(posedge clk) disable iff (!rstn)
		done_o |=> !out_valid_o);

endmodule

`default_nettype wire

// File: hw/cnn_accel_top.sv
`timescale 1ns/1ps
`default_nettype none

module cnn_accel_top (
	input  wire                clk,
	input  wire                rstn,
	input  wire                sl_hsel_i,
	input  wire                sl_hready_i,
	input  wire         [1:0]  sl_htrans_i,
	input  wire                sl_hwrite_i,
	input  wire         [31:0] sl_haddr_i,
	input  wire         [31:0] sl_hwdata_i,
	output logic        [31:0] sl_hrdata_o,
	output cnn_pkg::pix_t      out_pixel_o,
	output logic               out_valid_o
);
	import cnn_pkg::*;

	// ----------------------------------------
	// register bank outputs
	// ----------------------------------------
	logic                  img_we;
	idx_t                  img_addr;
	pix_t                  img_data;
	logic                  start;
	dim_t                  width;
	dim_t                  height;
	act_e                  act;
	logic [2:0]            act_shift;
	logic signed [BIAS_BITS-1:0] bias;
	weight_t               weights [N_TAPS];

	// ----------------------------------------
	// pipeline links
	// ----------------------------------------
	logic                  pos_vld;
	dim_t                  row;
	dim_t                  col;
	logic                  pos_last;
	logic                  win_vld;
	logic                  win_last;
	pix_t                  taps [N_TAPS];
	logic                  acc_vld;
	logic                  acc_last;
	acc_t                  acc;
	logic                  done;

	cnn_reg_bank u_reg_bank (
		.clk         (clk),
		.rstn        (rstn),
		.sl_hsel_i   (sl_hsel_i),
		.sl_hready_i (sl_hready_i),
		.sl_htrans_i (sl_htrans_i),
		.sl_hwrite_i (sl_hwrite_i),
		.sl_haddr_i  (sl_haddr_i),
		.sl_hwdata_i (sl_hwdata_i),
		.done_i      (done),
		.sl_hrdata_o (sl_hrdata_o),
		.img_we_o    (img_we),
		.img_addr_o  (img_addr),
		.img_data_o  (img_data),
		.start_o     (start),
		.width_o     (width),
		.height_o    (height),
		.act_o       (act),
		.act_shift_o (act_shift),
		.bias_o      (bias),
		.weights_o   (weights)
	);

	frame_sequencer u_seq (
		.clk       (clk),
		.rstn      (rstn),
		.start_i   (start),
		.width_i   (width),
		.height_i  (height),
		.pos_vld_o (pos_vld),
		.row_o     (row),
		.col_o     (col),
		.last_o    (pos_last)
	);

	window_fetch u_win (
		.clk        (clk),
		.rstn       (rstn),
		.img_we_i   (img_we),
		.img_addr_i (img_addr),
		.img_data_i (img_data),
		.width_i    (width),
		.height_i   (height),
		.pos_vld_i  (pos_vld),
		.row_i      (row),
		.col_i      (col),
		.last_i     (pos_last),
		.win_vld_o  (win_vld),
		.win_last_o (win_last),
		.taps_o     (taps)
	);

	mac_array u_mac (
		.clk        (clk),
		.rstn       (rstn),
		.win_vld_i  (win_vld),
		.win_last_i (win_last),
		.taps_i     (taps),
		.weights_i  (weights),
		.acc_vld_o  (acc_vld),
		.acc_last_o (acc_last),
		.acc_o      (acc)
	);

	post_proc u_post (
		.clk         (clk),
		.rstn        (rstn),
		.acc_vld_i   (acc_vld),
		.acc_last_i  (acc_last),
		.acc_i       (acc),
		.bias_i      (bias),
		.act_i       (act),
		.act_shift_i (act_shift),
		.out_valid_o (out_valid_o),
		.out_pixel_o (out_pixel_o),
		.done_o      (done)
	);

endmodule

`default_nettype wire

// File: verif/cnn_accel_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cnn_accel_tb;
	import cnn_pkg::*;

	localparam int TIMEOUT_CYC = 2000;

	// dut ports
	logic        clk;
	logic        rstn;
	logic        sl_hsel_i;
	logic        sl_hready_i;
	logic [1:0]  sl_htrans_i;
	logic        sl_hwrite_i;
	logic [31:0] sl_haddr_i;
	logic [31:0] sl_hwdata_i;
	logic [31:0] sl_hrdata_o;
	logic [7:0]  out_pixel_o;
	logic        out_valid_o;

	// layer setup mirrored in the testbench
	int                 fw;
	int                 fh;
	logic signed [7:0]  wt [9];
	int                 bias;
	int                 shift;
	logic               act_lin;
	logic [7:0]         img [256];
	logic [7:0]         exp_pix [256];

	// bookkeeping
	integer      seed = 32'h6d25_ca5b;
	int          cyc;
	int          out_cnt;
	int          frame_base;
	int          exp_n;
	int          start_cyc;
	int          err_cnt;
	int          to_cnt;
	logic [7:0]  out_idx;
	logic        rd_chk;
	logic [31:0] rd_exp;
	string       rd_name;

	cnn_accel_top UUT (
		.clk         (clk),
		.rstn        (rstn),
		.sl_hsel_i   (sl_hsel_i),
		.sl_hready_i (sl_hready_i),
		.sl_htrans_i (sl_htrans_i),
		.sl_hwrite_i (sl_hwrite_i),
		.sl_haddr_i  (sl_haddr_i),
		.sl_hwdata_i (sl_hwdata_i),
		.sl_hrdata_o (sl_hrdata_o),
		.out_pixel_o (out_pixel_o),
		.out_valid_o (out_valid_o)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	// cycle count and output count, both move on the rising edge
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (out_valid_o) begin
			out_cnt <= out_cnt + 1;
		end
	end

	assign out_idx = 8'(out_cnt - frame_base);

	// ----------------------------------------
	// checks, sampled on the falling edge
	// ----------------------------------------
	a_pixel: assert property (@(negedge clk) disable iff (!rstn)
		out_valid_o |-> (out_pixel_o == exp_pix[out_idx]))
	else begin
		err_cnt = err_cnt + 1;
		$display("CHECK FAILED t=%0t out_pixel_o expected %0d got %0d",
			$time, exp_pix[out_idx], out_pixel_o);
	end

	a_no_extra: assert property (@(negedge clk) disable iff (!rstn)
		out_valid_o |-> (out_cnt - frame_base < exp_n))
	else begin
		err_cnt = err_cnt + 1;
		$display("t=%0t the DUT produced more output pixels than the frame holds", $time);
	end

	// stream is one unbroken burst of width times height
	a_frame_len: assert property (@(negedge clk) disable iff (!rstn)
		$fell(out_valid_o) |-> (out_cnt - frame_base == exp_n))
	else begin
		err_cnt = err_cnt + 1;
		$display("CHECK FAILED t=%0t out_valid_o burst length expected %0d got %0d",
			$time, exp_n, out_cnt - frame_base);
	end

	// pixel 0 five cycles after the start capture edge
	a_latency: assert property (@(negedge clk) disable iff (!rstn)
		$rose(out_valid_o) |-> (cyc - start_cyc == 5))
	else begin
		err_cnt = err_cnt + 1;
		$display("CHECK FAILED t=%0t out_valid_o latency expected %0d got %0d",
			$time, 5, cyc - start_cyc);
	end

	a_readback: assert property (@(negedge clk) disable iff (!rstn)
		rd_chk |-> (sl_hrdata_o == rd_exp))
	else begin
		err_cnt = err_cnt + 1;
		$display("CHECK FAILED t=%0t sl_hrdata_o (%s) expected %h got %h",
			$time, rd_name, rd_exp, sl_hrdata_o);
	end

	// ----------------------------------------
	// bus tasks
	// ----------------------------------------
	// single nonseq write, idle data phase
	task automatic write_reg(input logic [3:0] idx, input logic [31:0] data,
		input logic [7:0] pix);
		@(negedge clk);
		sl_hsel_i   = 1'b1;
		sl_htrans_i = HTRANS_NONSEQ;
		sl_hwrite_i = 1'b1;
		sl_haddr_i  = {18'd0, pix, idx, 2'b00};
		@(negedge clk);
		sl_hsel_i   = 1'b0;
		sl_htrans_i = 2'b00;
		sl_hwrite_i = 1'b0;
		sl_hwdata_i = data;
		@(posedge clk);
		@(negedge clk);
	endtask

	// read, data checked by a_readback in the data phase
	task automatic read_check(input logic [3:0] idx, input logic [31:0] expv,
		input string name);
		@(negedge clk);
		sl_hsel_i   = 1'b1;
		sl_htrans_i = HTRANS_NONSEQ;
		sl_hwrite_i = 1'b0;
		sl_haddr_i  = {26'd0, idx, 2'b00};
		@(posedge clk);
		rd_exp  = expv;
		rd_name = name;
		rd_chk  = 1'b1;
		@(negedge clk);
		sl_hsel_i   = 1'b0;
		sl_htrans_i = 2'b00;
		@(posedge clk);
		rd_chk = 1'b0;
	endtask

	// ----------------------------------------
	// layer helpers and reference model
	// ----------------------------------------
	task automatic set_kernel();
		write_reg(REG_WIDTH_HEIGHT, {11'd0, 5'(fh), 11'd0, 5'(fw)}, 8'd0);
		write_reg(REG_WEIGHTS0, {wt[3], wt[2], wt[1], wt[0]}, 8'd0);
		write_reg(REG_WEIGHTS1, {wt[7], wt[6], wt[5], wt[4]}, 8'd0);
		write_reg(REG_WEIGHTS2, {24'd0, wt[8]}, 8'd0);
		write_reg(REG_BIAS, {16'd0, 16'(bias)}, 8'd0);
		write_reg(REG_LAYER_CONFIG, {16'd0, 3'(shift), 9'd0, act_lin, 3'd0}, 8'd0);
	endtask

	task automatic load_image();
		for (int i = 0; i < fw * fh; i++) begin
			img[8'(i)] = 8'($random(seed));
			write_reg(REG_INPUT_IMAGE, {24'd0, img[8'(i)]}, 8'(i));
		end
	endtask

	// zero padded 3x3 sum, bias, shift, clamp
	function automatic logic [7:0] model_pixel(input int r, input int c);
		int acc;
		int pr;
		int pc;
		acc = 0;
		for (int dr = -1; dr <= 1; dr++) begin
			for (int dc = -1; dc <= 1; dc++) begin
				pr = r + dr;
				pc = c + dc;
				if (pr >= 0 && pr < fh && pc >= 0 && pc < fw) begin
					acc = acc + int'(img[8'(pr * fw + pc)]) *
						int'(wt[4'((dr + 1) * 3 + dc + 1)]);
				end
			end
		end
		acc = (acc + bias) >>> shift;
		if (!act_lin) begin
			if (acc < 0) acc = 0;
			else if (acc > 255) acc = 255;
		end else begin
			if (acc < -128) acc = -128;
			else if (acc > 127) acc = 127;
		end
		return 8'(acc);
	endfunction

	task automatic prepare_frame();
		for (int r = 0; r < fh; r++) begin
			for (int c = 0; c < fw; c++) begin
				exp_pix[8'(r * fw + c)] = model_pixel(r, c);
			end
		end
		@(posedge clk);
		frame_base = out_cnt;
		exp_n      = fw * fh;
	endtask

	task automatic start_layer();
		write_reg(REG_LAYER_START, 32'd1, 8'd0);
		start_cyc = cyc;
	endtask

	// until the whole burst is out and valid has dropped
	task automatic wait_frame();
		int t;
		t = 0;
		@(negedge clk);
		while (!((out_cnt - frame_base >= exp_n) && !out_valid_o) && t < TIMEOUT_CYC) begin
			@(negedge clk);
			t++;
		end
		if (t >= TIMEOUT_CYC) begin
			to_cnt++;
			$display("t=%0t timeout while waiting for the output frame to finish", $time);
		end
	endtask

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	initial begin
		logic [31:0] v;
		rstn = 1'b0;
		sl_hsel_i = 1'b0;
		sl_hready_i = 1'b1;
		sl_htrans_i = 2'b00;
		sl_hwrite_i = 1'b0;
		sl_haddr_i = '0;
		sl_hwdata_i = '0;
		cyc = 0;
		out_cnt = 0;
		frame_base = 0;
		exp_n = 0;
		start_cyc = 0;
		err_cnt = 0;
		to_cnt = 0;
		rd_chk = 1'b0;
		rd_exp = '0;
		rd_name = "";
		repeat (3) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;

		// register readback, fields only
		read_check(REG_WIDTH_HEIGHT, 32'h0008_0008, "reset width height");
		v = $random(seed);
		write_reg(REG_WIDTH_HEIGHT, v, 8'd0);
		read_check(REG_WIDTH_HEIGHT, v & 32'h001f_001f, "width height");
		v = $random(seed);
		write_reg(REG_LAYER_CONFIG, v, 8'd0);
		read_check(REG_LAYER_CONFIG, v & 32'h0000_e008, "layer config");
		v = $random(seed);
		write_reg(REG_BIAS, v, 8'd0);
		read_check(REG_BIAS, v & 32'h0000_ffff, "bias");
		v = $random(seed);
		write_reg(REG_WEIGHTS0, v, 8'd0);
		read_check(REG_WEIGHTS0, v, "weights0");
		v = $random(seed);
		write_reg(REG_WEIGHTS1, v, 8'd0);
		read_check(REG_WEIGHTS1, v, "weights1");
		v = $random(seed);
		write_reg(REG_WEIGHTS2, v, 8'd0);
		read_check(REG_WEIGHTS2, v & 32'h0000_00ff, "weights2");
		read_check(4'd3, 32'd0, "unmapped 3");
		read_check(4'd15, 32'd0, "unmapped 15");
		read_check(REG_LAYER_START, 32'd0, "layer start");

		// identity kernel on 8x6
		fw = 8;
		fh = 6;
		for (int k = 0; k < 9; k++) wt[k] = 8'sd0;
		wt[4] = 8'sd1;
		bias = 0;
		shift = 0;
		act_lin = 1'b0;
		set_kernel();
		load_image();
		prepare_frame();
		start_layer();
		wait_frame();

		// box sum on 6x5, borders padded
		fw = 6;
		fh = 5;
		for (int k = 0; k < 9; k++) wt[k] = 8'sd1;
		shift = 3;
		set_kernel();
		load_image();
		prepare_frame();
		start_layer();
		wait_frame();

		// signed weights, relu then linear
		fw = 7;
		fh = 7;
		for (int k = 0; k < 9; k++) wt[k] = 8'($random(seed));
		bias = -300;
		shift = 2;
		set_kernel();
		load_image();
		prepare_frame();
		start_layer();
		wait_frame();
		// heavy negative bias drives the low clamp
		bias = -1000;
		act_lin = 1'b1;
		set_kernel();
		prepare_frame();
		start_layer();
		wait_frame();

		// done flag, restart mid frame is dropped
		fw = 12;
		fh = 9;
		set_kernel();
		load_image();
		prepare_frame();
		start_layer();
		read_check(REG_LAYER_DONE, 32'd0, "layer done while running");
		write_reg(REG_LAYER_START, 32'd1, 8'd0);
		wait_frame();
		read_check(REG_LAYER_DONE, 32'd1, "layer done after frame");

		repeat (4) @(negedge clk);
		$display("checks finished, %0d check errors, %0d timeouts", err_cnt, to_cnt);
		if (err_cnt == 0 && to_cnt == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
hw/cnn_pkg.sv
hw/cnn_reg_bank.sv
hw/frame_sequencer.sv
hw/window_fetch.sv
hw/mac_array.sv
hw/post_proc.sv
hw/cnn_accel_top.sv
verif/cnn_accel_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the cnn accelerator testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f all.f --top-module cnn_accel_tb -Mdir obj_dir -o cnn_sim

./obj_dir/cnn_sim > sim.log 2>&1
cat sim.log

if grep -q "^Simulation passed$" sim.log; then
	echo "PASS"
else
	echo "FAIL"
	exit 1
fi
